// ==== design/norm_if.sv ====
`timescale 1ns/1ps

interface norm_if import post_norm_pkg::*; ();

	logic      valid;
	mant_t     mantissa;
	logic      round_bit;
	logic      sticky;
	exp_wide_t exponent;
	logic      sign;
	rmode_t    rmode;

	// Shifter side
	modport src (
		output valid, mantissa, round_bit, sticky, exponent, sign, rmode
	);

	// Rounder side
	modport dst (
		input valid, mantissa, round_bit, sticky, exponent, sign, rmode
	);

endinterface

// ==== design/norm_shift.sv ====
`timescale 1ns/1ps

module norm_shift import post_norm_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  fract_in_t fract_in,
	input  exp_t      exp_in,
	input  logic      sign,
	input  rmode_t    rmode,
	input  norm_op_t  op,
	norm_if.src       nif
);

	lz_t       lz;
	lz_t       shamt;
	logic      fract_zero;
	exp_wide_t exp_next;
	fract_in_t shifted;

	assign fract_zero = (fract_in == '0);

	// --------------------
	// Leading zero count
	// Scan upwards so the highest set bit wins; all zeros gives 48
	always_comb
	begin
		lz = lz_t'(FRACT_W);
		for (int i = 0; i < FRACT_W; i++)
		begin
			if (fract_in[i])
				lz = lz_t'(FRACT_W - 1 - i);
		end
	end

	// --------------------
	// Shift amount and exponent
	always_comb
	begin
		if (op == OP_I2F)
		begin
			shamt    = lz;
			exp_next = I2F_EXP_BASE - exp_wide_t'(lz);
		end
		else if (exp_t'(lz) <= exp_in)
		begin
			// Hidden bit of a normal result lands on bit 47
			shamt    = lz;
			exp_next = exp_wide_t'(exp_in) + 10'sd1 - exp_wide_t'(lz);
		end
		else
		begin
			// Denormal result shifts only as far as the exponent allows
			// exp_in is below lz here, so it fits the count width
			shamt    = lz_t'(exp_in);
			exp_next = '0;
		end

		if (fract_zero)
			exp_next = '0;

		shifted = fract_in << shamt;
	end

	// --------------------
	// Stage one register
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			nif.valid <= 1'b0;
		else
			nif.valid <= start;
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			nif.mantissa  <= shifted[FRACT_W-2:FRACT_W-1-MANT_W];
			nif.round_bit <= shifted[FRACT_W-2-MANT_W];
			nif.sticky    <= |shifted[FRACT_W-3-MANT_W:0];
			nif.exponent  <= exp_next;
			nif.sign      <= sign;
			nif.rmode     <= rmode;
		end
	end

endmodule

// ==== design/post_norm_pkg.sv ====
package post_norm_pkg;

	// --------------------
	// Widths
	localparam int FRACT_W = 48;
	localparam int MANT_W  = 23;
	localparam int EXP_W   = 8;
	localparam int EXPW_W  = 10;
	localparam int LZ_W    = 6;

	typedef logic [FRACT_W-1:0]        fract_in_t;
	typedef logic [MANT_W-1:0]         mant_t;
	typedef logic [EXP_W-1:0]          exp_t;
	typedef logic signed [EXPW_W-1:0]  exp_wide_t;
	typedef logic [LZ_W-1:0]           lz_t;
	typedef logic [EXP_W+MANT_W-1:0]   result_t;

	// Same encoding as the rmode input of the FPU
	typedef enum logic [1:0] {
		RND_NEAREST = 2'b00,
		RND_ZERO    = 2'b01,
		RND_UP      = 2'b10,
		RND_DOWN    = 2'b11
	} rmode_t;

	typedef enum logic {
		OP_ADDSUB = 1'b0,
		OP_I2F    = 1'b1
	} norm_op_t;

	typedef enum logic [1:0] {
		HS_IDLE = 2'b00,
		HS_BUSY = 2'b01,
		HS_DONE = 2'b10
	} hs_state_t;

	// --------------------
	// Constants
	localparam exp_t      EXP_MAX        = 8'hff;
	localparam exp_t      EXP_FINITE_MAX = 8'hfe;
	localparam mant_t     MANT_ALL_ONES  = 23'h7fffff;
	// Exponent of an integer whose bit 47 is set, i.e. 2**31
	localparam exp_wide_t I2F_EXP_BASE   = 10'sd158;

endpackage

// ==== design/post_norm_top.sv ====
`timescale 1ns/1ps

module post_norm_top import post_norm_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      req,
	input  fract_in_t fract_in,
	input  exp_t      exp_in,
	input  logic      sign,
	input  rmode_t    rmode,
	input  norm_op_t  op,
	output logic      ack,
	output result_t   result,
	output logic      overflow,
	output logic      underflow,
	output logic      inexact
);

	logic      start;
	logic      done;
	fract_in_t cap_fract;
	exp_t      cap_exp;
	logic      cap_sign;
	rmode_t    cap_rmode;
	norm_op_t  cap_op;

	// Normalised value between the two stages
	norm_if u_nif ();

	req_ack_ctrl u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.fract_in  (fract_in),
		.exp_in    (exp_in),
		.sign      (sign),
		.rmode     (rmode),
		.op        (op),
		.done      (done),
		.ack       (ack),
		.start     (start),
		.cap_fract (cap_fract),
		.cap_exp   (cap_exp),
		.cap_sign  (cap_sign),
		.cap_rmode (cap_rmode),
		.cap_op    (cap_op)
	);

	norm_shift u_shift (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.fract_in (cap_fract),
		.exp_in   (cap_exp),
		.sign     (cap_sign),
		.rmode    (cap_rmode),
		.op       (cap_op),
		.nif      (u_nif.src)
	);

	round_pack u_round (
		.clk       (clk),
		.reset     (reset),
		.nif       (u_nif.dst),
		.result    (result),
		.overflow  (overflow),
		.underflow (underflow),
		.inexact   (inexact),
		.done      (done)
	);

endmodule

// ==== design/req_ack_ctrl.sv ====
`timescale 1ns/1ps

module req_ack_ctrl import post_norm_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      req,
	input  fract_in_t fract_in,
	input  exp_t      exp_in,
	input  logic      sign,
	input  rmode_t    rmode,
	input  norm_op_t  op,
	input  logic      done,
	output logic      ack,
	output logic      start,
	output fract_in_t cap_fract,
	output exp_t      cap_exp,
	output logic      cap_sign,
	output rmode_t    cap_rmode,
	output norm_op_t  cap_op
);

	hs_state_t state;
	logic      capture;

	// Operands are taken on the edge that sees req while idle
	assign capture = (state == HS_IDLE) && req;

	// --------------------
	// Handshake FSM
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= HS_IDLE;
			ack   <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			start <= capture;
			case (state)
			HS_IDLE:
				if (req)
					state <= HS_BUSY;
			HS_BUSY:
				if (done)
				begin
					ack   <= 1'b1;
					state <= HS_DONE;
				end
			HS_DONE:
				// Result is held until the requester lets go
				if (!req)
				begin
					ack   <= 1'b0;
					state <= HS_IDLE;
				end
			default:
				state <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			cap_fract <= fract_in;
			cap_exp   <= exp_in;
			cap_sign  <= sign;
			cap_rmode <= rmode;
			cap_op    <= op;
		end
	end

endmodule

// ==== design/round_pack.sv ====
`timescale 1ns/1ps

module round_pack import post_norm_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	norm_if.dst     nif,
	output result_t result,
	output logic    overflow,
	output logic    underflow,
	output logic    inexact,
	output logic    done
);

	logic        lsb;
	logic        inc;
	logic        carry;
	logic        to_inf;
	logic        overflow_c;
	logic        underflow_c;
	logic        inexact_c;
	logic [MANT_W:0] mant_sum;
	mant_t       mant_rnd;
	exp_wide_t   exp_rnd;
	result_t     result_c;

	assign lsb = nif.mantissa[0];

	// --------------------
	// Increment decision
	always_comb
	begin
		case (nif.rmode)
		RND_NEAREST:
			inc = nif.round_bit & (lsb | nif.sticky);
		RND_ZERO:
			inc = 1'b0;
		RND_UP:
			inc = (nif.round_bit | nif.sticky) & !nif.sign;
		RND_DOWN:
			inc = (nif.round_bit | nif.sticky) & nif.sign;
		default:
			inc = 1'b0;
		endcase
	end

	// Mantissa carry clears the fraction and bumps the exponent;
	// a denormal at exponent 0 moves to 1 the same way
	assign mant_sum = {1'b0, nif.mantissa} + {{MANT_W{1'b0}}, inc};
	assign carry    = mant_sum[MANT_W];
	assign mant_rnd = mant_sum[MANT_W-1:0];
	assign exp_rnd  = carry ? nif.exponent + 10'sd1 : nif.exponent;

	// --------------------
	// Overflow and flags
	assign overflow_c = exp_rnd >= exp_wide_t'(EXP_MAX);

	// Infinity unless rounding goes toward zero for this sign
	assign to_inf = (nif.rmode == RND_NEAREST) ||
			((nif.rmode == RND_UP) && !nif.sign) ||
			((nif.rmode == RND_DOWN) && nif.sign);

	always_comb
	begin
		if (overflow_c && to_inf)
			result_c = {EXP_MAX, mant_t'(0)};
		else if (overflow_c)
			result_c = {EXP_FINITE_MAX, MANT_ALL_ONES};
		else
			result_c = {exp_rnd[EXP_W-1:0], mant_rnd};
	end

	assign inexact_c   = nif.round_bit | nif.sticky | overflow_c;
	assign underflow_c = (exp_rnd == '0) && inexact_c;

	// --------------------
	// Stage two register
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			done      <= 1'b0;
			result    <= '0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
			inexact   <= 1'b0;
		end
		else
		begin
			done <= nif.valid;
			if (nif.valid)
			begin
				result    <= result_c;
				overflow  <= overflow_c;
				underflow <= underflow_c;
				inexact   <= inexact_c;
			end
		end
	end

endmodule

// ==== post_norm.f ====
design/post_norm_pkg.sv
design/norm_if.sv
design/req_ack_ctrl.sv
design/norm_shift.sv
design/round_pack.sv
design/post_norm_top.sv
test/post_norm_asserts.sv
test/post_norm_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run the testbench, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module post_norm_tb -f post_norm.f &&
./obj_dir/Vpost_norm_tb > "$LOG" 2>&1 ||
echo "build or simulation did not complete"

cat "$LOG" 2>/dev/null

grep -q "^Simulation finished: PASS$" "$LOG" &&
echo "RESULT: pass" ||
{ echo "RESULT: fail"; exit 1; }

// ==== test/post_norm_asserts.sv ====
`timescale 1ns/1ps

module post_norm_asserts
(
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input logic overflow,
	input logic inexact
);

	// --------------------
	// Handshake
	// ack is set on the edge before it is first seen high
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))
	else
		$error("ack rose while req was low");

	// Result is held until the requester lets go
	ack_holds: assert property (@(posedge clk) disable iff (reset)
		(ack && req) |=> ack)
	else
		$error("ack fell while req was still high");

	// --------------------
	// Flags
	overflow_inexact: assert property (@(posedge clk) disable iff (reset)
		overflow |-> inexact)
	else
		$error("overflow set without inexact");

endmodule

// ==== test/post_norm_tb.sv ====
`timescale 1ns/1ps

module post_norm_tb import post_norm_pkg::*; ();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_LATENCY  = 3;
	localparam int ACK_LIMIT    = 20;
	// Upper bound on operations over all tests
	localparam int MAX_OPS      = 200;
	localparam int WATCHDOG_NS  = (MAX_OPS * 10 + RESET_CYCLES + 100) * CLK_PERIOD;

	logic      clk;
	logic      reset;
	logic      req;
	fract_in_t fract_in;
	exp_t      exp_in;
	logic      sign;
	rmode_t    rmode;
	norm_op_t  op;
	logic      ack;
	result_t   result;
	logic      overflow;
	logic      underflow;
	logic      inexact;

	int          errors = 0;
	int          ops = 0;
	int          tests = 0;
	logic [31:0] lfsr = 32'h889d099d;

	post_norm_top u_post_norm_top (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.fract_in  (fract_in),
		.exp_in    (exp_in),
		.sign      (sign),
		.rmode     (rmode),
		.op        (op),
		.ack       (ack),
		.result    (result),
		.overflow  (overflow),
		.underflow (underflow),
		.inexact   (inexact)
	);

	bind post_norm_top post_norm_asserts u_asserts (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.ack      (ack),
		.overflow (overflow),
		.inexact  (inexact)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the tests did not complete", $time);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// --------------------
	// Stimulus helpers

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [47:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[46:0], lfsr[0]};
		end
	endtask

	// Hidden bit set, then mantissa, round bit and the bits below it
	function automatic fract_in_t build_fract(input mant_t m, input logic r,
			input logic [22:0] low);
		return {1'b1, m, r, low};
	endfunction

	// --------------------
	// Reference model
	function automatic void ref_model(input fract_in_t f, input exp_t e_in, input logic s,
			input rmode_t m, input norm_op_t o, output result_t r, output logic ovf,
			output logic unf, output logic inx);
		int          lz;
		int          sh;
		int          e;
		logic [47:0] v;
		mant_t       mant;
		logic        rnd;
		logic        stk;
		logic        up;
		logic [23:0] sum;
		logic        to_inf;
		lz = 48;
		for (int i = 0; i < 48; i++)
		begin
			if (f[47-i] && lz == 48)
				lz = i;
		end
		if (o == OP_I2F)
		begin
			sh = lz;
			e  = 158 - lz;
		end
		else if (lz <= int'(e_in))
		begin
			sh = lz;
			e  = int'(e_in) + 1 - lz;
		end
		else
		begin
			sh = int'(e_in);
			e  = 0;
		end
		if (f == '0)
			e = 0;
		v    = f << sh;
		mant = v[46:24];
		rnd  = v[23];
		stk  = |v[22:0];
		case (m)
		RND_NEAREST: up = rnd & (mant[0] | stk);
		RND_UP:      up = (rnd | stk) & !s;
		RND_DOWN:    up = (rnd | stk) & s;
		default:     up = 1'b0;
		endcase
		sum  = {1'b0, mant} + 24'(up);
		mant = sum[22:0];
		if (sum[23])
			e = e + 1;
		ovf    = (e >= 255);
		inx    = rnd | stk | ovf;
		unf    = (e == 0) && inx;
		to_inf = (m == RND_NEAREST) || (m == RND_UP && !s) || (m == RND_DOWN && s);
		if (ovf)
			r = to_inf ? {EXP_MAX, 23'h0} : {EXP_FINITE_MAX, MANT_ALL_ONES};
		else
			r = {exp_t'(e), mant};
	endfunction

	// --------------------
	// Compare tasks
	task automatic check_result(input string name, input result_t got, input result_t want);
		if (got !== want)
		begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, want);
		end
	endtask

	// Full four-phase transfer that starts and ends just after a rising edge
	task automatic do_op(input fract_in_t f, input exp_t e, input logic s, input rmode_t m,
			input norm_op_t o, input int hold);
		result_t want;
		logic    want_ovf;
		logic    want_unf;
		logic    want_inx;
		int      n;
		ref_model(f, e, s, m, o, want, want_ovf, want_unf, want_inx);
		fract_in = f;
		exp_in   = e;
		sign     = s;
		rmode    = m;
		op       = o;
		req      = 1'b1;
		@(posedge clk);
		#1;
		n = 0;
		while (!ack && n < ACK_LIMIT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		ops++;
		if (!ack)
		begin
			errors++;
			$display("no ack within %0d cycles for fract %h exp %h", ACK_LIMIT, f, e);
		end
		else
		begin
			if (n != ACK_LATENCY)
			begin
				errors++;
				$display("ack came %0d cycles after req instead of %0d", n, ACK_LATENCY);
			end
			repeat (hold)
			begin
				@(posedge clk);
				#1;
				if (!ack)
				begin
					errors++;
					$display("ack dropped while req was still high");
				end
			end
			check_result("result", result, want);
			check_flag("overflow", overflow, want_ovf);
			check_flag("underflow", underflow, want_unf);
			check_flag("inexact", inexact, want_inx);
		end
		req = 1'b0;
		n   = 0;
		while (ack && n < ACK_LIMIT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ack || n != 1)
		begin
			errors++;
			$display("ack did not fall one cycle after req was dropped");
		end
	endtask

	task automatic report_test(input string name, input int op0, input int err0);
		tests++;
		$display("%-20s %0d ops, %0d errors", name, ops - op0, errors - err0);
	endtask

	// --------------------
	// Tests
	task automatic handshake_timing();
		int          op0;
		int          err0;
		logic [47:0] f;
		logic [47:0] sh;
		logic [47:0] v;
		op0  = ops;
		err0 = errors;
		// Called right after reset release
		check_flag("ack", ack, 1'b0);
		do_op(48'h9234_5678_9abc, 8'd120, 1'b0, RND_NEAREST, OP_ADDSUB, 3);
		do_op(48'h0003_ffff_ffff, 8'd90, 1'b1, RND_DOWN, OP_ADDSUB, 5);
		// Back-to-back random operands with a random number of leading zeros
		for (int i = 0; i < 100; i++)
		begin
			take_bits(48, f);
			take_bits(6, sh);
			take_bits(12, v);
			do_op(f >> sh[5:0], exp_t'(v[7:0]), v[8], rmode_t'(v[10:9]),
				norm_op_t'(v[11]), 0);
		end
		report_test("handshake_timing", op0, err0);
	endtask

	task automatic normalised_add();
		int op0;
		int err0;
		op0  = ops;
		err0 = errors;
		do_op(48'h8000_0000_0000, 8'd100, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'hc000_0040_0000, 8'd127, 1'b1, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h0123_4567_89ab, 8'd130, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h0000_00ff_ffff, 8'd60, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h00ff_0000_0000, 8'd90, 1'b1, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h8000_0000_0001, 8'd200, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		report_test("normalised_add", op0, err0);
	endtask

	task automatic rounding_modes();
		int          op0;
		int          err0;
		mant_t       mants[5];
		logic        rnds[5];
		logic [22:0] lows[5];
		op0  = ops;
		err0 = errors;
		// Tie on even, tie on odd, above half, below half, carry out
		mants = '{23'h000000, 23'h000001, 23'h2aaaaa, 23'h155555, 23'h7fffff};
		rnds  = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
		lows  = '{23'h0, 23'h0, 23'h1, 23'h400000, 23'h7fffff};
		for (int p = 0; p < 5; p++)
			for (int m = 0; m < 4; m++)
				for (int s = 0; s < 2; s++)
					do_op(build_fract(mants[p], rnds[p], lows[p]), 8'd127, s[0],
						rmode_t'(m[1:0]), OP_ADDSUB, 0);
		report_test("rounding_modes", op0, err0);
	endtask

	task automatic denormal_underflow();
		int op0;
		int err0;
		op0  = ops;
		err0 = errors;
		do_op(48'h0000_0000_1234, 8'd3, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h0001_2300_0000, 8'd2, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h0000_0100_0001, 8'd5, 1'b1, RND_ZERO, OP_ADDSUB, 0);
		do_op(48'h0000_0000_0000, 8'd0, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		// Largest denormal that rounds up into exponent 1
		do_op(48'h7fff_ff80_0000, 8'd0, 1'b0, RND_NEAREST, OP_ADDSUB, 0);
		do_op(48'h7fff_ff80_0000, 8'd0, 1'b0, RND_UP, OP_ADDSUB, 0);
		do_op(48'h7fff_ff80_0000, 8'd0, 1'b0, RND_ZERO, OP_ADDSUB, 0);
		report_test("denormal_underflow", op0, err0);
	endtask

	task automatic overflow_clamp();
		int op0;
		int err0;
		op0  = ops;
		err0 = errors;
		for (int m = 0; m < 4; m++)
			for (int s = 0; s < 2; s++)
			begin
				do_op(build_fract(MANT_ALL_ONES, 1'b1, 23'h1), 8'd253, s[0],
					rmode_t'(m[1:0]), OP_ADDSUB, 0);
				do_op(build_fract(23'h100000, 1'b0, 23'h0), 8'd254, s[0],
					rmode_t'(m[1:0]), OP_ADDSUB, 0);
			end
		report_test("overflow_clamp", op0, err0);
	endtask

	task automatic int_to_float();
		int          op0;
		int          err0;
		logic [31:0] ints[8];
		op0  = ops;
		err0 = errors;
		ints = '{32'h0, 32'h1, 32'h00ff_ffff, 32'h0100_0001,
			32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h1234_5678};
		for (int i = 0; i < 8; i++)
		begin
			do_op({ints[i], 16'h0}, 8'h5a, i[0], RND_NEAREST, OP_I2F, 0);
			do_op({ints[i], 16'h0}, 8'h5a, i[0], RND_ZERO, OP_I2F, 0);
		end
		report_test("int_to_float", op0, err0);
	endtask

	// --------------------
	// Main sequence
	initial
	begin
		reset    = 1'b1;
		req      = 1'b0;
		fract_in = '0;
		exp_in   = '0;
		sign     = 1'b0;
		rmode    = RND_NEAREST;
		op       = OP_ADDSUB;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		handshake_timing();
		normalised_add();
		rounding_modes();
		denormal_underflow();
		overflow_clamp();
		int_to_float();
		$display("%0d tests, %0d operations, %0d errors", tests, ops, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
